// ==== verilog/rcomp_pkg.sv ====
// ==============================
// RCOMP calibration shared types, state encoding
// and code / divide limits
// ==============================

package rcomp_pkg;

  // ==============================
  // Widths
  // ==============================
  localparam int RCOMP_CODE_W = 7;    // Gen1/Gen2 limits assume 7 bits
  localparam int RCOMP_DIV_W  = 6;    // Div by 1, 2, 4, 8, 16, 32
  localparam int RCOMP_CNT_W  = 5;    // Enough for a terminal count of 31

  typedef logic [RCOMP_CODE_W-1:0] rcomp_code_t;
  typedef logic [RCOMP_DIV_W-1:0]  rcomp_div_sel_t;
  typedef logic [RCOMP_CNT_W-1:0]  rcomp_div_cnt_t;

  // ==============================
  // Calibration FSM
  // ==============================
  typedef enum logic [1:0] {
    RCOMP_START = 2'b00,  // Idle, clear count and history
    RCOMP_COUNT = 2'b01,  // Counting ticks until the comparator flips
    RCOMP_STOP  = 2'b10   // Code held, done raised
  } rcomp_state_t;

  // Count limits per mode
  localparam rcomp_code_t RCOMP_GEN1_MAX = 7'd63;
  localparam rcomp_code_t RCOMP_GEN2_MAX = 7'd127;

  // Divide by 1 out of reset
  localparam rcomp_div_sel_t RCOMP_DIV_RESET = 6'b000001;

endpackage

// ==== verilog/rcomp_div_sel.sv ====
// ==============================
// Divide select capture with load ack and
// sampling tick generator
// ==============================

`timescale 1ns/1ps

module rcomp_div_sel
  import rcomp_pkg::*;
(
  input  logic           sys_div_clk,
  input  logic           rst_n,
  input  logic           scan_mode,          // Forces divide by 1
  input  logic           clk_div_ld,         // One-cycle load strobe
  input  rcomp_div_sel_t clk_div_onehot,     // Bit 0 = div 1 ... bit 5 = div 32
  output logic           sample_tick,
  output logic           div_restart,
  output logic           clk_div_ld_ack_ff
);

  rcomp_div_sel_t div_sel_q;   // Active ratio
  rcomp_div_cnt_t term_cnt;
  rcomp_div_cnt_t div_cnt;
  logic           load_ok;
  logic           cnt_wrap;

  // Exactly one bit set, otherwise the load is ignored
  assign load_ok = (clk_div_onehot != '0) &&
                   ((clk_div_onehot & (clk_div_onehot - 1'b1)) == '0);

  // ==============================
  // Select capture and ack
  // ==============================
  always_ff @(posedge sys_div_clk or negedge rst_n) begin
    if (!rst_n) begin
      div_sel_q         <= RCOMP_DIV_RESET;
      div_restart       <= 1'b0;
      clk_div_ld_ack_ff <= 1'b0;
    end else begin
      clk_div_ld_ack_ff <= clk_div_ld;            // Ack every load, valid or not
      div_restart       <= clk_div_ld & load_ok;
      if (clk_div_ld && load_ok) begin
        div_sel_q <= clk_div_onehot;
      end
    end
  end

  // Terminal count is ratio minus one
  always_comb begin
    term_cnt = '0;
    if (!scan_mode) begin
      case (div_sel_q)
        6'b000010: term_cnt = 5'd1;
        6'b000100: term_cnt = 5'd3;
        6'b001000: term_cnt = 5'd7;
        6'b010000: term_cnt = 5'd15;
        6'b100000: term_cnt = 5'd31;
        default:   term_cnt = 5'd0;   // Div by 1
      endcase
    end
  end

  // ==============================
  // Tick counter
  // ==============================
  // Compare with >= so a shrinking ratio (scan entry) wraps at once
  assign cnt_wrap = (div_cnt >= term_cnt);

  always_ff @(posedge sys_div_clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
    end else if (div_restart || cnt_wrap) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // First tick lands N cycles after the restart pulse
  assign sample_tick = cnt_wrap & ~div_restart;

endmodule

// ==== verilog/rcomp_cal_counter.sv ====
// ==============================
// Pad comparator synchronizer, calibration FSM
// and tick counter with edge capture
// ==============================

`timescale 1ns/1ps

module rcomp_cal_counter
  import rcomp_pkg::*;
(
  input  logic        sys_div_clk,
  input  logic        rst_n,
  input  logic        sample_tick,   // Enable for all FSM and count updates
  input  logic        div_restart,   // New ratio, back to start
  input  logic        start_cal,     // Level, held until done is seen
  input  logic        pad_data,      // Async replica comparator
  input  logic        gen1mode_en,
  output rcomp_code_t raw_code,
  output logic        cal_done_raw,
  output logic        cal_en
);

  rcomp_state_t state;
  rcomp_state_t state_nxt;
  rcomp_code_t  count;
  rcomp_code_t  count_limit;
  logic [1:0]   hist;            // Last two sampled comparator levels
  logic         pad_meta;
  logic         pad_sync;
  logic         edge_seen;
  logic         at_limit;

  // ==============================
  // Pad synchronizer
  // ==============================
  // Runs every cycle, not just on ticks
  always_ff @(posedge sys_div_clk or negedge rst_n) begin
    if (!rst_n) begin
      pad_meta <= 1'b0;
      pad_sync <= 1'b0;
    end else begin
      pad_meta <= pad_data;
      pad_sync <= pad_meta;
    end
  end

  assign count_limit = gen1mode_en ? RCOMP_GEN1_MAX : RCOMP_GEN2_MAX;
  assign edge_seen   = hist[1] ^ hist[0];
  assign at_limit    = (count == count_limit);

  // ==============================
  // State machine
  // ==============================
  always_comb begin
    state_nxt = state;
    if (div_restart) begin
      state_nxt = RCOMP_START;
    end else if (sample_tick) begin
      case (state)
        RCOMP_START: begin
          if (start_cal) begin
            state_nxt = RCOMP_COUNT;
          end
        end
        RCOMP_COUNT: begin
          if (edge_seen || at_limit) begin
            state_nxt = RCOMP_STOP;
          end
        end
        RCOMP_STOP: begin
          if (!start_cal) begin
            state_nxt = RCOMP_START;
          end
        end
        default: state_nxt = RCOMP_START;
      endcase
    end
  end

  always_ff @(posedge sys_div_clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= RCOMP_START;
    end else begin
      state <= state_nxt;
    end
  end

  // ==============================
  // Count, history and held code
  // ==============================
  always_ff @(posedge sys_div_clk or negedge rst_n) begin
    if (!rst_n) begin
      count    <= '0;
      hist     <= 2'b00;
      raw_code <= '0;
      cal_en   <= 1'b0;
    end else if (sample_tick) begin
      case (state)
        RCOMP_START: begin
          count  <= '0;
          hist   <= 2'b00;
          cal_en <= 1'b1;
        end
        RCOMP_COUNT: begin
          hist <= {hist[0], pad_sync};
          if (edge_seen) begin
            // Comparator already flipped, keep the previous step
            raw_code <= count - 1'b1;
            cal_en   <= 1'b0;
          end else if (at_limit) begin
            raw_code <= count_limit;    // Saturate, no edge found
            cal_en   <= 1'b0;
          end else begin
            count <= count + 1'b1;
          end
        end
        RCOMP_STOP: cal_en <= 1'b0;
        default: begin
          count  <= '0;
          hist   <= 2'b00;
          cal_en <= 1'b0;
        end
      endcase
    end
  end

  assign cal_done_raw = (state == RCOMP_STOP);

endmodule

// ==== verilog/rcomp_code_out.sv ====
// ==============================
// Output code register with Gen1/Gen2 shaping,
// override and scan forcing, done output
// ==============================

`timescale 1ns/1ps

module rcomp_code_out
  import rcomp_pkg::*;
(
  input  logic        sys_div_clk,
  input  logic        rst_n,
  input  rcomp_code_t raw_code,
  input  logic        cal_done_raw,
  input  logic        gen1mode_en,
  input  logic        scan_mode,
  input  logic        rcomp_cal_ovrd_sel,    // Register override enable
  input  logic        rcomp_cal_done_ovrd,
  input  rcomp_code_t rcomp_cal_code_ovrd,
  output rcomp_code_t rcomp_cal_code,
  output logic        rcomp_cal_done
);

  rcomp_code_t code_shaped;
  rcomp_code_t code_nxt;
  logic        done_nxt;

  // Gen2 pads take the inverted count
  assign code_shaped = gen1mode_en ? raw_code : ~raw_code;

  // ==============================
  // Output select
  // ==============================
  always_comb begin
    if (scan_mode) begin
      code_nxt = '0;
    end else if (rcomp_cal_ovrd_sel) begin
      code_nxt = rcomp_cal_code_ovrd;
    end else begin
      code_nxt = code_shaped;
    end
  end

  // Scan does not touch done
  assign done_nxt = rcomp_cal_ovrd_sel ? rcomp_cal_done_ovrd : cal_done_raw;

  // Registered so the pad never sees a mux glitch
  always_ff @(posedge sys_div_clk or negedge rst_n) begin
    if (!rst_n) begin
      rcomp_cal_code <= '0;
      rcomp_cal_done <= 1'b0;
    end else begin
      rcomp_cal_code <= code_nxt;
      rcomp_cal_done <= done_nxt;
    end
  end

endmodule

// ==== verilog/rcomp_cal_top.sv ====
// ==============================
// RCOMP calibration top level
// ==============================

`timescale 1ns/1ps

module rcomp_cal_top
  import rcomp_pkg::*;
(
  input  logic           sys_div_clk,
  input  logic           rst_n,
  input  logic           rcomp_cal_ovrd_sel,
  input  logic           rcomp_cal_done_ovrd,
  input  rcomp_code_t    rcomp_cal_code_ovrd,
  input  logic           start_cal,
  input  logic           pad_data,
  input  logic           gen1mode_en,
  input  logic           scan_mode,
  input  logic           clk_div_ld,
  input  rcomp_div_sel_t clk_div_onehot,
  output logic           rcomp_cal_done,
  output logic           rcomp_cal_en,
  output rcomp_code_t    rcomp_cal_code,
  output logic           rcomp_clk_div_ld_ack_ff
);

  logic        sample_tick;
  logic        div_restart;
  logic        cal_done_raw;
  rcomp_code_t raw_code;

  // Decode
  rcomp_div_sel u_div_sel (
    .sys_div_clk       (sys_div_clk),
    .rst_n             (rst_n),
    .scan_mode         (scan_mode),
    .clk_div_ld        (clk_div_ld),
    .clk_div_onehot    (clk_div_onehot),
    .sample_tick       (sample_tick),
    .div_restart       (div_restart),
    .clk_div_ld_ack_ff (rcomp_clk_div_ld_ack_ff)
  );

  // Execute
  rcomp_cal_counter u_cal_counter (
    .sys_div_clk  (sys_div_clk),
    .rst_n        (rst_n),
    .sample_tick  (sample_tick),
    .div_restart  (div_restart),
    .start_cal    (start_cal),
    .pad_data     (pad_data),
    .gen1mode_en  (gen1mode_en),
    .raw_code     (raw_code),
    .cal_done_raw (cal_done_raw),
    .cal_en       (rcomp_cal_en)        // Straight out to the pad
  );

  // Result
  rcomp_code_out u_code_out (
    .sys_div_clk         (sys_div_clk),
    .rst_n               (rst_n),
    .raw_code            (raw_code),
    .cal_done_raw        (cal_done_raw),
    .gen1mode_en         (gen1mode_en),
    .scan_mode           (scan_mode),
    .rcomp_cal_ovrd_sel  (rcomp_cal_ovrd_sel),
    .rcomp_cal_done_ovrd (rcomp_cal_done_ovrd),
    .rcomp_cal_code_ovrd (rcomp_cal_code_ovrd),
    .rcomp_cal_code      (rcomp_cal_code),
    .rcomp_cal_done      (rcomp_cal_done)
  );

endmodule

// ==== verification/rcomp_cal_model.svh ====
// ==============================
// LFSR source, cycle-level RCOMP reference model
// and typed compare tasks
// ==============================

`ifndef RCOMP_CAL_MODEL_SVH
`define RCOMP_CAL_MODEL_SVH

logic [31:0]    lfsr_state;
int             err_code;
int             err_bit;
int             err_lat;

// Model registers
rcomp_div_sel_t m_sel;
rcomp_div_cnt_t m_cnt;
logic           m_restart;
logic           m_ack;
logic           m_meta;
logic           m_sync;
rcomp_state_t   m_state;
rcomp_code_t    m_count;
logic [1:0]     m_hist;
rcomp_code_t    m_raw;
logic           m_cal_en;
rcomp_code_t    m_code;
logic           m_done;

// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  int          i;
  v = '0;
  for (i = 0; i < n; i++) begin
    lfsr_state = {lfsr_state[30:0],
                  lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
    v = {v[30:0], lfsr_state[0]};
  end
  return v;
endfunction

task automatic model_reset();
  m_sel     = RCOMP_DIV_RESET;
  m_cnt     = '0;
  m_restart = 1'b0;
  m_ack     = 1'b0;
  m_meta    = 1'b0;
  m_sync    = 1'b0;
  m_state   = RCOMP_START;
  m_count   = '0;
  m_hist    = 2'b00;
  m_raw     = '0;
  m_cal_en  = 1'b0;
  m_code    = '0;
  m_done    = 1'b0;
endtask

// One clock of the model, every update from the values before the edge
task automatic model_step(input logic scan, input logic ld, input rcomp_div_sel_t onehot,
                          input logic start, input logic pad, input logic gen1,
                          input logic ovrd_sel, input logic done_ovrd,
                          input rcomp_code_t code_ovrd);
  rcomp_div_cnt_t term;
  rcomp_code_t    lim;
  logic           wrap;
  logic           tick;
  logic           edge_s;
  int             i;
  term = '0;
  if (!scan) begin
    for (i = 0; i < 6; i++) begin
      if (m_sel[i]) term = rcomp_div_cnt_t'((1 << i) - 1);
    end
  end
  wrap   = (m_cnt >= term);
  tick   = wrap && !m_restart;
  lim    = gen1 ? RCOMP_GEN1_MAX : RCOMP_GEN2_MAX;
  edge_s = m_hist[1] ^ m_hist[0];
  // ==============================
  // Output register
  // ==============================
  if (scan) m_code = '0;
  else if (ovrd_sel) m_code = code_ovrd;
  else m_code = gen1 ? m_raw : ~m_raw;
  m_done = ovrd_sel ? done_ovrd : (m_state == RCOMP_STOP);
  // ==============================
  // Calibration rules
  // ==============================
  if (m_restart) begin
    m_state = RCOMP_START;
  end else if (tick) begin
    case (m_state)
      RCOMP_START: begin
        m_count  = '0;
        m_hist   = 2'b00;
        m_cal_en = 1'b1;
        if (start) m_state = RCOMP_COUNT;
      end
      RCOMP_COUNT: begin
        m_hist = {m_hist[0], m_sync};
        if (edge_s) begin
          m_raw    = m_count - 1'b1;
          m_cal_en = 1'b0;
          m_state  = RCOMP_STOP;
        end else if (m_count == lim) begin
          m_raw    = lim;
          m_cal_en = 1'b0;
          m_state  = RCOMP_STOP;
        end else begin
          m_count = m_count + 1'b1;
        end
      end
      default: begin
        m_cal_en = 1'b0;
        if (!start) m_state = RCOMP_START;
      end
    endcase
  end
  m_sync    = m_meta;   // Two-flop synchronizer
  m_meta    = pad;
  m_cnt     = (m_restart || wrap) ? '0 : m_cnt + 1'b1;
  m_restart = ld && ($countones(onehot) == 1);
  m_ack     = ld;
  if (ld && ($countones(onehot) == 1)) m_sel = onehot;
endtask

task automatic check_code(input string name, input rcomp_code_t exp, input rcomp_code_t act);
  if (exp !== act) begin
    $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
    err_code++;
  end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  if (exp !== act) begin
    $display("FAILED %s: expected %b, actual %b", name, exp, act);
    err_bit++;
  end
endtask

task automatic check_state_free_count(input string name, input int exp, input int act);
  if (exp != act) begin
    $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
    err_lat++;
  end
endtask

`endif

// ==== verification/rcomp_cal_tb.sv ====
// ==============================
// RCOMP calibration testbench, random scenarios
// checked cycle by cycle against a model
// ==============================

`timescale 1ns/1ps

module rcomp_cal_tb
  import rcomp_pkg::*;
;

  localparam int N_SCEN      = 20;
  localparam int CYCLE_LIMIT = N_SCEN * 32 * (128 + 8) + 4000;

  logic           sys_div_clk;
  logic           rst_n;
  logic           rcomp_cal_ovrd_sel;
  logic           rcomp_cal_done_ovrd;
  rcomp_code_t    rcomp_cal_code_ovrd;
  logic           start_cal;
  logic           pad_data;
  logic           gen1mode_en;
  logic           scan_mode;
  logic           clk_div_ld;
  rcomp_div_sel_t clk_div_onehot;
  logic           rcomp_cal_done;
  logic           rcomp_cal_en;
  rcomp_code_t    rcomp_cal_code;
  logic           ack;
  logic           checking;
  int             cycle_cnt;
  int             cur_ratio;
  int             i;
  int             idx;
  rcomp_div_sel_t bad;
  rcomp_code_t    v;
  logic           d;

  `include "rcomp_cal_model.svh"

  rcomp_cal_top DUT (
    .sys_div_clk             (sys_div_clk),
    .rst_n                   (rst_n),
    .rcomp_cal_ovrd_sel      (rcomp_cal_ovrd_sel),
    .rcomp_cal_done_ovrd     (rcomp_cal_done_ovrd),
    .rcomp_cal_code_ovrd     (rcomp_cal_code_ovrd),
    .start_cal               (start_cal),
    .pad_data                (pad_data),
    .gen1mode_en             (gen1mode_en),
    .scan_mode               (scan_mode),
    .clk_div_ld              (clk_div_ld),
    .clk_div_onehot          (clk_div_onehot),
    .rcomp_cal_done          (rcomp_cal_done),
    .rcomp_cal_en            (rcomp_cal_en),
    .rcomp_cal_code          (rcomp_cal_code),
    .rcomp_clk_div_ld_ack_ff (ack)
  );

  always #5 sys_div_clk = ~sys_div_clk;

  // Model runs beside the DUT on the same edges
  always @(posedge sys_div_clk or negedge rst_n) begin
    if (!rst_n) model_reset();
    else model_step(scan_mode, clk_div_ld, clk_div_onehot, start_cal, pad_data,
                    gen1mode_en, rcomp_cal_ovrd_sel, rcomp_cal_done_ovrd,
                    rcomp_cal_code_ovrd);
  end

  // ==============================
  // Run limit
  // ==============================
  always @(posedge sys_div_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test FAILED");
      $finish;
    end
  end

  // Outputs are stable on the falling edge
  task automatic next_cycle();
    @(negedge sys_div_clk);
    if (checking) begin
      check_code("cycle code", m_code, rcomp_cal_code);
      check_bit("cycle done", m_done, rcomp_cal_done);
      check_bit("cycle cal_en", m_cal_en, rcomp_cal_en);
      check_bit("cycle ack", m_ack, ack);
    end
  endtask

  task automatic wait_idle();
    while (m_state != RCOMP_START || m_done) next_cycle();
  endtask

  task automatic load_div(input string name, input rcomp_div_sel_t sel);
    clk_div_onehot = sel;
    clk_div_ld     = 1'b1;
    next_cycle();
    clk_div_ld = 1'b0;
    check_bit({name, " ack"}, 1'b1, ack);
    next_cycle();
    check_bit({name, " ack drop"}, 1'b0, ack);
  endtask

  // One calibration with the pad flipping flip_at cycles in (never if negative)
  task automatic run_cal(input string name, input logic gen1, input int flip_at);
    int cyc;
    int dut_lat;
    int mod_lat;
    int k;
    gen1mode_en = gen1;
    pad_data    = 1'b0;
    next_cycle();
    start_cal = 1'b1;
    cyc       = 0;
    dut_lat   = -1;
    mod_lat   = -1;
    while (dut_lat < 0 || mod_lat < 0) begin
      next_cycle();
      cyc++;
      if (rcomp_cal_done && dut_lat < 0) dut_lat = cyc;
      if (m_done && mod_lat < 0) mod_lat = cyc;
      if (cyc == flip_at) pad_data = ~pad_data;
    end
    check_state_free_count({name, " latency"}, mod_lat, dut_lat);
    for (k = 0; k < 3; k++) begin
      next_cycle();
      check_bit({name, " done hold"}, 1'b1, rcomp_cal_done);
    end
    if (flip_at < 0 && !scan_mode) begin
      check_code({name, " saturated"}, gen1 ? 7'd63 : 7'd0, rcomp_cal_code);
    end
    start_cal = 1'b0;
    wait_idle();
    check_bit({name, " done clear"}, 1'b0, rcomp_cal_done);
    pad_data = 1'b0;
    repeat (4) next_cycle();
  endtask

  initial begin
    sys_div_clk         = 1'b0;
    rst_n               = 1'b0;
    rcomp_cal_ovrd_sel  = 1'b0;
    rcomp_cal_done_ovrd = 1'b0;
    rcomp_cal_code_ovrd = '0;
    start_cal           = 1'b0;
    pad_data            = 1'b0;
    gen1mode_en         = 1'b1;
    scan_mode           = 1'b0;
    clk_div_ld          = 1'b0;
    clk_div_onehot      = RCOMP_DIV_RESET;
    lfsr_state          = 32'hfe4a91ed;
    err_code            = 0;
    err_bit             = 0;
    err_lat             = 0;
    cycle_cnt           = 0;
    checking            = 1'b0;
    cur_ratio           = 1;
    model_reset();
    repeat (2) @(negedge sys_div_clk);
    rst_n = 1'b1;
    check_bit("reset done", 1'b0, rcomp_cal_done);
    check_bit("reset cal_en", 1'b0, rcomp_cal_en);
    check_code("reset code", 7'd0, rcomp_cal_code);
    check_bit("reset ack", 1'b0, ack);
    checking = 1'b1;

    // ==============================
    // Gen1 and Gen2 at ratio 1
    // ==============================
    for (i = 0; i < 3; i++) run_cal("gen1 edge", 1'b1, int'(rand_bits(6)) + 2);
    for (i = 0; i < 3; i++) run_cal("gen2 edge", 1'b0, int'(rand_bits(6)) + 2);
    run_cal("gen1 no edge", 1'b1, -1);
    run_cal("gen2 no edge", 1'b0, -1);

    // Divide ratios with valid and invalid loads
    for (i = 0; i < 6; i++) begin
      idx       = int'(rand_bits(3)) % 6;
      cur_ratio = 1 << idx;
      load_div("div load", rcomp_div_sel_t'(1 << idx));
      run_cal("div cal", rand_bits(1) == 1, (int'(rand_bits(5)) + 2) * cur_ratio);
    end
    for (i = 0; i < 2; i++) begin
      bad = rcomp_div_sel_t'(rand_bits(6));
      if ($countones(bad) == 1) bad = bad | 6'b000011;
      load_div("bad load", bad);
      run_cal("bad load cal", 1'b1, (int'(rand_bits(5)) + 2) * cur_ratio);
    end

    // ==============================
    // Override and scan
    // ==============================
    rcomp_cal_ovrd_sel = 1'b1;
    start_cal          = 1'b1;
    for (i = 0; i < 8; i++) begin
      v                   = rcomp_code_t'(rand_bits(7));
      d                   = rand_bits(1) == 1;
      rcomp_cal_code_ovrd = v;
      rcomp_cal_done_ovrd = d;
      next_cycle();
      check_code("override code", v, rcomp_cal_code);
      check_bit("override done", d, rcomp_cal_done);
    end
    start_cal          = 1'b0;
    rcomp_cal_ovrd_sel = 1'b0;
    wait_idle();
    // Slow ratio so scan has a ratio to override
    cur_ratio = 16;
    load_div("scan div load", 6'b010000);
    scan_mode = 1'b1;
    next_cycle();
    run_cal("scan cal", 1'b1, int'(rand_bits(5)) + 2);
    check_code("scan code", 7'd0, rcomp_cal_code);
    scan_mode = 1'b0;
    next_cycle();

    // Back-to-back calibrations
    run_cal("repeat cal a", 1'b1, (int'(rand_bits(5)) + 2) * cur_ratio);
    run_cal("repeat cal b", 1'b0, (int'(rand_bits(5)) + 2) * cur_ratio);

    $display("Errors: code %0d, bit %0d, latency %0d", err_code, err_bit, err_lat);
    if (err_code + err_bit + err_lat == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+verification
verilog/rcomp_pkg.sv
verilog/rcomp_div_sel.sv
verilog/rcomp_cal_counter.sv
verilog/rcomp_code_out.sv
verilog/rcomp_cal_top.sv
verification/rcomp_cal_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = rcomp_cal_tb
FILELIST = all.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -qx "Test OK" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
